/* rtl/flitMux.sv */
`default_nettype none

module flitMux
  import nocPkg::*;
(
  input logic clk,
  input logic rst,
  input grantT grant,
  input flitT inFlit [NumPorts],
  output flitT outFlit
);

  localparam int FlitBits = $bits(flitT);

  logic [FlitBits-1:0] masked [NumPorts];
  logic [FlitBits-1:0] selBits;
  flitT selFlit;

  // each input is kept only when its grant bit is set
  for (genvar p = 0; p < NumPorts; p++)
  begin : genMask
    assign masked[p] = inFlit[p] & {FlitBits{grant[p]}};
  end

  // grant is one-hot, so or-ing the masked inputs selects at most one
  always_comb
  begin
    selBits = '0;
    for (int p = 0; p < NumPorts; p++)
      selBits = selBits | masked[p];
  end

  assign selFlit = flitT'(selBits); // all zero when nothing is granted

  always_ff @(posedge clk)
  begin
    if (rst)
      outFlit <= '0;
    else
      outFlit <= selFlit;
  end

endmodule

`default_nettype wire

/* rtl/holdTimer.sv */
`default_nettype none

module holdTimer
  import nocPkg::*;
(
  input logic clk,
  input logic rst,
  input flitT inFlit,
  input logic runTimer,
  output logic timesUp
);

  lengthT holdLimit;
  lengthT holdCount;
  logic isHeader;

  assign isHeader = inFlit.valid && (inFlit.flitId == FlitHeader);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLimit <= '0;
    end
    else if (isHeader)
    begin
      holdLimit <= inFlit.payload[LenBits-1:0]; // used from the next cycle on
    end
  end

  // the count only runs while the port is actually being held
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdCount <= '0;
    end
    else if (runTimer)
    begin
      holdCount <= holdCount + 1'b1;
    end
    else
    begin
      holdCount <= '0;
    end
  end

  assign timesUp = (holdCount == holdLimit);

endmodule

`default_nettype wire

/* rtl/nocPkg.sv */
`default_nettype none

package nocPkg;

  localparam int NumPorts = 5;

  // port indices, same order as the request priority when idle
  localparam int PortL = 0;
  localparam int PortN = 1;
  localparam int PortE = 2;
  localparam int PortW = 3;
  localparam int PortS = 4;

  localparam int FlitIdBits = 3;
  localparam int LenBits = 12;
  localparam int PayloadBits = 32;

  typedef logic [FlitIdBits-1:0] flitIdT;
  typedef logic [LenBits-1:0] lengthT; // hold length in clock periods
  typedef logic [PayloadBits-1:0] payloadT;

  localparam flitIdT FlitHeader = 3'd1;
  localparam flitIdT FlitBody = 3'd2;
  localparam flitIdT FlitTail = 3'd3;

  // a header flit carries its length in the low bits of the payload
  typedef struct packed {
    logic valid; // strobe, only meaningful for the cycle it is seen
    flitIdT flitId;
    payloadT payload;
  } flitT;

  typedef logic [NumPorts-1:0] grantT; // one-hot, zero when idle
  typedef logic [NumPorts-1:0] reqT;

  typedef enum logic [NumPorts:0] {
    ArbIdle = 6'b000001,
    ArbL = 6'b000010,
    ArbN = 6'b000100,
    ArbE = 6'b001000,
    ArbW = 6'b010000,
    ArbS = 6'b100000
  } arbStateT;

endpackage

`default_nettype wire

/* rtl/outputPort.sv */
`default_nettype none

module outputPort
  import nocPkg::*;
(
  input logic clk,
  input logic rst,
  input reqT req,
  input flitT inFlit [NumPorts],
  output grantT grant,
  output flitT outFlit
);

  grantT portGrant;

  assign grant = portGrant;

  // grant lags req by one cycle
  portArbiter portArbiter_i (
    .clk(clk),
    .rst(rst),
    .req(req),
    .inFlit(inFlit),
    .grant(portGrant)
  );

  // and outFlit lags grant by one more
  flitMux flitMux_i (
    .clk(clk),
    .rst(rst),
    .grant(portGrant),
    .inFlit(inFlit),
    .outFlit(outFlit)
  );

endmodule

`default_nettype wire

/* rtl/portArbiter.sv */
`default_nettype none

module portArbiter
  import nocPkg::*;
(
  input logic clk,
  input logic rst,
  input reqT req,
  input flitT inFlit [NumPorts],
  output grantT grant
);

  arbStateT state;
  arbStateT nextState;
  logic [NumPorts-1:0] runTimer;
  logic [NumPorts-1:0] timesUp;
  logic holdValid; // state is a port state, not idle
  int holder;
  int startPort;

  function automatic arbStateT stateOf(input int port);
    arbStateT st;
    case (port)
      PortL: st = ArbL;
      PortN: st = ArbN;
      PortE: st = ArbE;
      PortW: st = ArbW;
      PortS: st = ArbS;
      default: st = ArbIdle;
    endcase
    return st;
  endfunction

  // first requesting port going round from first, wrapping past South
  function automatic arbStateT pickNext(input reqT r, input int first);
    arbStateT pick;
    int idx;
    pick = ArbIdle;
    for (int i = NumPorts - 1; i >= 0; i--)
    begin
      idx = first + i;
      if (idx >= NumPorts)
        idx = idx - NumPorts;
      if (r[idx])
        pick = stateOf(idx); // lowest offset is written last and wins
    end
    return pick;
  endfunction

  for (genvar p = 0; p < NumPorts; p++)
  begin : genTimer
    holdTimer holdTimer_i (
      .clk(clk),
      .rst(rst),
      .inFlit(inFlit[p]),
      .runTimer(runTimer[p]),
      .timesUp(timesUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ArbIdle;
    else
      state <= nextState;
  end

  // rotation table: holder and where the search for the next port starts
  always_comb
  begin
    holdValid = 1'b1;
    holder = PortL;
    startPort = PortL;
    case (state)
      ArbL:
      begin
        holder = PortL;
        startPort = PortN;
      end
      ArbN:
      begin
        holder = PortN;
        startPort = PortE;
      end
      ArbE:
      begin
        holder = PortE;
        startPort = PortW;
      end
      ArbW:
      begin
        holder = PortW;
        startPort = PortS;
      end
      ArbS:
      begin
        holder = PortS;
        startPort = PortL; // wraps back to Local like any other port
      end
      default:
      begin
        holdValid = 1'b0; // idle uses plain L, N, E, W, S priority
        startPort = PortL;
      end
    endcase
  end

  always_comb
  begin
    runTimer = '0;
    if (holdValid && req[holder] && !timesUp[holder])
    begin
      runTimer[holder] = 1'b1;
      nextState = state;
    end
    else
    begin
      nextState = pickNext(req, startPort); // holder itself is checked last
    end
  end

  // grant comes straight from the registered state
  always_comb
  begin
    for (int p = 0; p < NumPorts; p++)
      grant[p] = (state == stateOf(p));
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+test
rtl/nocPkg.sv
rtl/holdTimer.sv
rtl/portArbiter.sv
rtl/flitMux.sv
rtl/outputPort.sv
test/outputPortTb.sv

/* test/tbChecks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// error counters shared by the compare tasks and the closing report
int grantErrors = 0;
int flitErrors = 0;
int otherErrors = 0;

task automatic checkGrant(
  input string testName,
  input grantT expected,
  input grantT actual
);
  if (actual !== expected)
  begin
    grantErrors++;
    $display("FAIL %s grant expected %h actual %h at %0t",
      testName, expected, actual, $time);
  end
endtask

// whole flit compared, valid and flitId included
task automatic checkFlit(
  input string testName,
  input flitT expected,
  input flitT actual
);
  if (actual !== expected)
  begin
    flitErrors++;
    $display("FAIL %s outFlit expected %h actual %h at %0t",
      testName, expected, actual, $time);
  end
endtask

`endif

/* test/outputPortTb.sv */
`default_nettype none

module outputPortTb
  import nocPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod = 10;
  localparam int ResetCycles = 10;
  localparam int ResetTimeout = 50;
  localparam int CheckDelay = 4; // one ns before the next rising edge
  localparam int MaxLines = 1000;
  localparam int FlitBits = $bits(flitT);
  localparam string VectorFile = "test/outputPortVectors.txt";

  logic clk;
  logic rst;
  reqT req;
  flitT inFlit [NumPorts];
  grantT grant;
  flitT outFlit;

  `include "tbChecks.svh"

  outputPort outputPort_i (
    .clk(clk),
    .rst(rst),
    .req(req),
    .inFlit(inFlit),
    .grant(grant),
    .outFlit(outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0; // released on a falling edge like every other input
  end

  // returns on the first rising edge that sees reset low
  task automatic waitForReset(output logic released);
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
    end
    while (rst !== 1'b0 && cycles < ResetTimeout);
    released = (rst === 1'b0);
  endtask

  function automatic bit isDataLine(input string text);
    bit result;
    result = 1'b1;
    if (text.len() < 2)
      result = 1'b0;
    else if (text.getc(0) == "/")
      result = 1'b0; // comment line
    return result;
  endfunction

  task automatic applyVectors();
    int fd;
    int got;
    int lineNo;
    int fields;
    int applied;
    string lineText;
    string label;
    reqT rawReq;
    logic [FlitBits-1:0] rawFlit [NumPorts];
    grantT expGrant;
    logic [FlitBits-1:0] expFlit;
    lineNo = 0;
    applied = 0;
    fd = $fopen(VectorFile, "r");
    if (fd == 0)
    begin
      $display("could not open the vector file %s", VectorFile);
      otherErrors++;
    end
    else
    begin
      while (!$feof(fd) && lineNo < MaxLines)
      begin
        lineText = "";
        got = $fgets(lineText, fd);
        lineNo++;
        if (got != 0 && isDataLine(lineText))
        begin
          fields = $sscanf(lineText, "%s %h %h %h %h %h %h %h %h", label, rawReq,
            rawFlit[0], rawFlit[1], rawFlit[2], rawFlit[3], rawFlit[4], expGrant, expFlit);
          if (fields != 9)
          begin
            $display("line %0d of the vector file could not be read, %0d fields found",
              lineNo, fields);
            otherErrors++;
          end
          else
          begin
            @(negedge clk);
            req = rawReq;
            for (int p = 0; p < NumPorts; p++)
              inFlit[p] = flitT'(rawFlit[p]);
            #(CheckDelay); // outputs are registered and settled by now
            checkGrant(label, expGrant, grant);
            checkFlit(label, flitT'(expFlit), outFlit);
            applied++;
          end
        end
      end
      $fclose(fd);
      if (applied == 0)
      begin
        $display("the vector file held no usable lines");
        otherErrors++;
      end
    end
  endtask

  initial
  begin
    logic released;
    int totalErrors;
    req = '0;
    for (int p = 0; p < NumPorts; p++)
      inFlit[p] = '0;
    waitForReset(released);
    if (!released)
    begin
      $display("reset was still asserted after %0d cycles", ResetTimeout);
      otherErrors++;
    end
    else
    begin
      applyVectors();
    end
    totalErrors = grantErrors + flitErrors + otherErrors;
    $display("grant errors %0d, flit errors %0d, other errors %0d",
      grantErrors, flitErrors, otherErrors);
    if (totalErrors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* test/outputPortVectors.txt */
// columns are label, req, the L N E W S input flits, expected grant and expected outFlit
// all values are hex and a flit is valid, flitId and payload packed into 36 bits
// idle with no requests, then simultaneous first requests from idle
idle     00 000000000 000000000 000000000 000000000 000000000 00 000000000
idle     00 A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 00 000000000
idle     00 B000E0000 B000E0001 B000E0002 B000E0003 B000E0004 00 000000000
prio     1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 00 000000000
prio     00 A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 01 000000000
prio     1E A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 00 A000B0000
prio     00 A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 02 000000000
prio     1C A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 00 A000B0001
prio     00 A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 04 000000000
prio     18 A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 00 A000B0002
prio     00 A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 08 000000000
prio     10 A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 00 A000B0003
prio     00 A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 10 000000000
// L gets length 3 and N length 0, both request
hdr      00 900000003 900100000 000000000 000000000 000000000 00 A000B0004
hold3    03 A000B0000 A000B0001 000000000 000000000 000000000 00 000000000
hold3    03 A000B0000 A000B0001 000000000 000000000 000000000 01 000000000
hold3    03 A000B0000 A000B0001 000000000 000000000 000000000 01 A000B0000
hold3    03 A000B0000 A000B0001 000000000 000000000 000000000 01 A000B0000
hold3    03 A000B0000 A000B0001 000000000 000000000 000000000 01 A000B0000
hold0    03 A000B0000 A000B0001 000000000 000000000 000000000 02 A000B0000
hold3    03 A000B0000 A000B0001 000000000 000000000 000000000 01 A000B0001
hold3    03 A000B0000 A000B0001 000000000 000000000 000000000 01 A000B0000
hold3    03 A000B0000 A000B0001 000000000 000000000 000000000 01 A000B0000
hold3    03 A000B0000 A000B0001 000000000 000000000 000000000 01 A000B0000
hold3    00 A000B0000 A000B0001 000000000 000000000 000000000 02 A000B0000
// E gets length 7 and shares with W
hdr      00 000000000 000000000 900200007 000000000 000000000 00 A000B0001
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 00 000000000
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 04 000000000
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 04 A000B0002
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 04 A000B0002
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 04 A000B0002
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 04 A000B0002
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 04 A000B0002
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 04 A000B0002
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 04 A000B0002
hold7    0C 000000000 000000000 A000B0002 A000B0003 000000000 08 A000B0002
hold7    00 000000000 000000000 A000B0002 A000B0003 000000000 04 A000B0003
// lengths L 1, E 0, S 1, then every port requests
hdr      00 900000001 000000000 900200000 000000000 900400001 00 A000B0002
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 00 000000000
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 01 000000000
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 01 A000B0000
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 02 A000B0000
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 04 A000B0001
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 08 A000B0002
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 10 A000B0003
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 10 A000B0004
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 01 A000B0004
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 01 A000B0000
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 02 A000B0000
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 04 A000B0001
rotate   1F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 08 A000B0002
release  0F A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 10 A000B0003
release  0E A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 01 A000B0004
release  00 A000B0000 A000B0001 A000B0002 A000B0003 A000B0004 02 A000B0000
// W gets length 2 and requests alone, N joins later
hdr      00 000000000 000000000 000000000 900300002 000000000 00 A000B0001
sole     08 000000000 A000B0001 000000000 A000B0003 000000000 00 000000000
sole     08 000000000 A000B0001 000000000 A000B0003 000000000 08 000000000
sole     08 000000000 A000B0001 000000000 A000B0003 000000000 08 A000B0003
sole     08 000000000 A000B0001 000000000 A000B0003 000000000 08 A000B0003
sole     08 000000000 A000B0001 000000000 A000B0003 000000000 08 A000B0003
sole     0A 000000000 A000B0001 000000000 A000B0003 000000000 08 A000B0003
sole     0A 000000000 A000B0001 000000000 A000B0003 000000000 08 A000B0003
sole     0A 000000000 A000B0001 000000000 A000B0003 000000000 02 A000B0003
sole     00 000000000 A000B0001 000000000 A000B0003 000000000 08 A000B0001
// N gets length 3, a new header arrives in its last held cycle
hdr      00 000000000 900100003 000000000 000000000 000000000 00 A000B0003
fwd      12 B000E0000 A00C00001 A000B0002 B000E0003 A000B0004 00 000000000
fwd      12 B000E0000 A00C00002 A000B0002 B000E0003 A000B0004 02 000000000
fwd      12 B000E0000 A00C00003 A000B0002 B000E0003 A000B0004 02 A00C00002
fwd      12 B000E0000 A00C00004 A000B0002 B000E0003 A000B0004 02 A00C00003
midHdr   12 B000E0000 900100001 A000B0002 B000E0003 A000B0004 02 A00C00004
fwd      12 B000E0000 A00C00005 A000B0002 B000E0003 A000B0004 10 900100001
fwd      12 B000E0000 A00C00006 A000B0002 B000E0003 A000B0004 10 A000B0004
newHold  12 B000E0000 A00C00007 A000B0002 B000E0003 A000B0004 02 A000B0004
newHold  12 B000E0000 A00C00008 A000B0002 B000E0003 A000B0004 02 A00C00007
fwd      00 B000E0000 A00C00009 A000B0002 B000E0003 A000B0004 10 A00C00008
idle     00 000000000 000000000 000000000 000000000 000000000 00 A000B0004
idle     00 000000000 000000000 000000000 000000000 000000000 00 000000000
